// ==== hdl/dac_pkg.sv ====
package dac_pkg;

	////////////////////////////////////////
	// frame layout constants
	////////////////////////////////////////

	// bits per spi transfer
	localparam int FRAME_BITS = 32;

	// fixed leading nibble of every frame
	localparam logic [3:0] FRAME_PREFIX = 4'b1000;

	// fixed trailing byte of every frame
	localparam logic [7:0] FRAME_TRAILER = 8'd1;

	////////////////////////////////////////
	// request and frame types
	////////////////////////////////////////

	// one dac request, 20 bits
	typedef struct packed {
		logic [3:0]  cmd;
		logic [3:0]  addr;
		logic [11:0] data;
	} dac_req_t;

	// field view of the frame, msb first on the wire
	typedef struct packed {
		logic [3:0]  prefix;
		logic [11:0] data;
		logic [3:0]  addr;
		logic [3:0]  cmd;
		logic [7:0]  trailer;
	} dac_frame_fields_t;

	// raw bits for the shifter, fields for the echo check
	typedef union packed {
		logic [FRAME_BITS-1:0] raw;
		dac_frame_fields_t     f;
	} dac_frame_u;

	// echo check result seen by the host
	typedef struct packed {
		logic       echo_valid;
		logic       echo_match;
		logic [7:0] err_count;
	} dac_status_t;

endpackage

// ==== hdl/sck_tick_gen.sv ====
`timescale 1ns/1ps

module sck_tick_gen #(
	parameter int TICK_DIV = 4
) (
	input  logic CLK50MHZ,
	input  logic RST,
	output logic spi_sck_trig
);

	// keep at least one bit when no division is asked for
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;

	////////////////////////////////////////
	// free running divider
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			div_cnt <= '0;
		end else if (div_cnt == CNT_W'(TICK_DIV - 1)) begin
			// wrap at the end of one tick period
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// strobe on the last count of each period
	assign spi_sck_trig = (div_cnt == CNT_W'(TICK_DIV - 1));

	// strobe spacing, only meaningful with a real divider
	a_tick_spacing: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		(TICK_DIV > 1 && spi_sck_trig) |=> !spi_sck_trig)
		else $error("sck_tick_gen: tick strobe high on consecutive cycles");

endmodule

// ==== hdl/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter import dac_pkg::*; (
	input  logic       CLK50MHZ,
	input  logic       RST,
	input  logic       spi_sck_trig,
	input  logic       spi_trig,
	input  dac_frame_u data_in,
	output dac_frame_u data_out,
	output logic       SPI_SCK,
	output logic       SPI_MOSI,
	input  logic       SPI_MISO,
	output logic       busy,
	output logic       spi_done
);

	// two ticks per bit
	localparam int TICKS = 2 * FRAME_BITS;
	localparam int TCNT_W = $clog2(TICKS);

	logic [TCNT_W-1:0]     tick_cnt;
	logic [FRAME_BITS-1:0] tx_sr;
	dac_frame_u            rx_sr;
	logic                  start;
	logic                  last_tick;

	////////////////////////////////////////
	// handshake
	////////////////////////////////////////

	// trigger only counts on a tick while idle
	assign start = spi_sck_trig & spi_trig & ~busy;

	// 64th tick after acceptance, sck falls here
	assign last_tick = busy & spi_sck_trig & (tick_cnt == TCNT_W'(TICKS - 1));

	// done is high during the cycle of the last tick
	assign spi_done = last_tick;

	////////////////////////////////////////
	// control, tick count and sck
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			busy     <= 1'b0;
			tick_cnt <= '0;
			SPI_SCK  <= 1'b0;
		end else if (start) begin
			// first bit is already on mosi, sck stays low
			busy     <= 1'b1;
			tick_cnt <= '0;
			SPI_SCK  <= 1'b0;
		end else if (busy && spi_sck_trig) begin
			tick_cnt <= tick_cnt + 1'b1;
			// even count rises, odd count falls
			SPI_SCK  <= ~tick_cnt[0];
			if (last_tick) begin
				busy <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// shift registers
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (start) begin
			tx_sr <= data_in.raw;
		end else if (busy && spi_sck_trig) begin
			if (!tick_cnt[0]) begin
				// rising edge, sample miso msb first
				rx_sr.raw <= {rx_sr.raw[FRAME_BITS-2:0], SPI_MISO};
			end else begin
				// falling edge, next bit onto mosi
				tx_sr <= {tx_sr[FRAME_BITS-2:0], 1'b0};
			end
		end
	end

	// msb first
	assign SPI_MOSI = tx_sr[FRAME_BITS-1];

	// full word is in place by the last tick
	assign data_out = rx_sr;

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_done_pulse: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		spi_done |=> !spi_done)
		else $error("spi_shifter: spi_done longer than one cycle");

	a_sck_idle: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		!busy |-> !SPI_SCK)
		else $error("spi_shifter: sck high while idle");

endmodule

// ==== hdl/dacspi.sv ====
`timescale 1ns/1ps

module dacspi import dac_pkg::*; (
	input  logic       CLK50MHZ,
	input  logic       RST,
	input  logic       spi_sck_trig,
	input  dac_req_t   req,
	input  logic       dactrig,
	output logic       DAC_CS,
	output logic       DAC_CLR,
	output logic       SPI_SCK,
	output logic       SPI_MOSI,
	input  logic       DAC_OUT,
	output dac_frame_u echo,
	output logic       busy,
	output logic       dacdone
);

	dac_frame_u tx_frame;
	logic       start;

	////////////////////////////////////////
	// frame assembly
	////////////////////////////////////////

	always_comb begin
		tx_frame.f.prefix  = FRAME_PREFIX;
		tx_frame.f.data    = req.data;
		tx_frame.f.addr    = req.addr;
		tx_frame.f.cmd     = req.cmd;
		tx_frame.f.trailer = FRAME_TRAILER;
	end

	// same acceptance rule as inside the shifter
	assign start = spi_sck_trig & dactrig & ~busy;

	////////////////////////////////////////
	// serial engine
	////////////////////////////////////////

	spi_shifter u_shifter (
		.CLK50MHZ     (CLK50MHZ),
		.RST          (RST),
		.spi_sck_trig (spi_sck_trig),
		.spi_trig     (dactrig),
		.data_in      (tx_frame),
		.data_out     (echo),
		.SPI_SCK      (SPI_SCK),
		.SPI_MOSI     (SPI_MOSI),
		.SPI_MISO     (DAC_OUT),
		.busy         (busy),
		.spi_done     (dacdone)
	);

	////////////////////////////////////////
	// dac control pins
	////////////////////////////////////////

	// chip select frames the transfer
	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			DAC_CS <= 1'b1;
		end else if (start) begin
			DAC_CS <= 1'b0;
		end else if (dacdone) begin
			// released on the edge closing the last tick
			DAC_CS <= 1'b1;
		end
	end

	// clear held low while in reset
	always_comb begin
		DAC_CLR = RST;
	end

	// cs and shifter state move on the same edges
	a_cs_busy: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		DAC_CS == !busy)
		else $error("dacspi: DAC_CS out of step with shifter busy");

endmodule

// ==== hdl/echo_checker.sv ====
`timescale 1ns/1ps

module echo_checker import dac_pkg::*; #(
	parameter int ERR_W = 8
) (
	input  logic        CLK50MHZ,
	input  logic        RST,
	input  logic        spi_sck_trig,
	input  dac_req_t    req,
	input  logic        dactrig,
	input  logic        busy,
	input  logic        dacdone,
	input  dac_frame_u  echo,
	output dac_status_t status
);

	dac_req_t         pend_req;
	dac_req_t         prev_req;
	logic             have_prev;
	logic             valid_q;
	logic             match_q;
	logic [ERR_W-1:0] err_cnt;
	logic             accept;
	logic             fields_eq;

	// request is taken on the cycle the framer accepts it
	assign accept = spi_sck_trig & dactrig & ~busy;

	// echo carries the frame sent one transfer back
	always_comb begin
		fields_eq = (echo.f.cmd == prev_req.cmd) &&
			(echo.f.addr == prev_req.addr) &&
			(echo.f.data == prev_req.data);
	end

	////////////////////////////////////////
	// request history
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (accept) begin
			pend_req <= req;
		end
		if (dacdone) begin
			prev_req <= pend_req;
		end
	end

	////////////////////////////////////////
	// judgement and error count
	////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			have_prev <= 1'b0;
			valid_q   <= 1'b0;
			match_q   <= 1'b0;
			err_cnt   <= '0;
		end else begin
			valid_q <= 1'b0;
			if (dacdone) begin
				have_prev <= 1'b1;
				// nothing to compare on the first transfer
				if (have_prev) begin
					valid_q <= 1'b1;
					match_q <= fields_eq;
					if (!fields_eq && err_cnt != '1) begin
						err_cnt <= err_cnt + 1'b1;
					end
				end
			end
		end
	end

	always_comb begin
		status.echo_valid = valid_q;
		status.echo_match = match_q;
		status.err_count  = err_cnt;
	end

endmodule

// ==== hdl/dac_subsystem.sv ====
`timescale 1ns/1ps

module dac_subsystem import dac_pkg::*; #(
	parameter int TICK_DIV = 4,
	parameter int ERR_W    = 8
) (
	input  logic        CLK50MHZ,
	input  logic        RST,
	input  dac_req_t    req,
	input  logic        dactrig,
	output logic        dacdone,
	output dac_status_t status,
	output logic        DAC_CS,
	output logic        DAC_CLR,
	output logic        SPI_SCK,
	output logic        SPI_MOSI,
	input  logic        DAC_OUT
);

	logic       spi_sck_trig;
	logic       busy;
	dac_frame_u echo;

	////////////////////////////////////////
	// tick generator
	////////////////////////////////////////

	sck_tick_gen #(
		.TICK_DIV (TICK_DIV)
	) u_tick (
		.CLK50MHZ     (CLK50MHZ),
		.RST          (RST),
		.spi_sck_trig (spi_sck_trig)
	);

	////////////////////////////////////////
	// framer and spi pins
	////////////////////////////////////////

	dacspi u_dacspi (
		.CLK50MHZ     (CLK50MHZ),
		.RST          (RST),
		.spi_sck_trig (spi_sck_trig),
		.req          (req),
		.dactrig      (dactrig),
		.DAC_CS       (DAC_CS),
		.DAC_CLR      (DAC_CLR),
		.SPI_SCK      (SPI_SCK),
		.SPI_MOSI     (SPI_MOSI),
		.DAC_OUT      (DAC_OUT),
		.echo         (echo),
		.busy         (busy),
		.dacdone      (dacdone)
	);

	////////////////////////////////////////
	// echo checker
	////////////////////////////////////////

	echo_checker #(
		.ERR_W (ERR_W)
	) u_checker (
		.CLK50MHZ     (CLK50MHZ),
		.RST          (RST),
		.spi_sck_trig (spi_sck_trig),
		.req          (req),
		.dactrig      (dactrig),
		.busy         (busy),
		.dacdone      (dacdone),
		.echo         (echo),
		.status       (status)
	);

	// counter width must fit the status field
	a_err_width: assert property (@(posedge CLK50MHZ)
		ERR_W == $bits(status.err_count))
		else $error("dac_subsystem: ERR_W does not match status err_count width");

endmodule

// ==== tb/ltc_dac_model.sv ====
`timescale 1ns/1ps

module ltc_dac_model import dac_pkg::*; (
	input  logic        DAC_CS,
	input  logic        SPI_SCK,
	input  logic        SPI_MOSI,
	output logic        DAC_OUT,
	input  logic        corrupt,
	input  logic [4:0]  corrupt_bit,
	output dac_frame_u  frame,
	output int unsigned frame_cnt
);

	logic [31:0] rx_sr;
	logic [31:0] tx_sr;
	logic [31:0] last_word;
	int unsigned bit_cnt;

	// a fresh part echoes zeros on its first transfer
	initial begin
		rx_sr     = '0;
		tx_sr     = '0;
		last_word = '0;
		bit_cnt   = 0;
		frame     = '0;
		frame_cnt = 0;
	end

	////////////////////////////////////////
	// echo side
	////////////////////////////////////////

	// previous frame goes out, one bit flipped on request
	always @(negedge DAC_CS) begin
		if (corrupt) begin
			tx_sr <= last_word ^ (32'd1 << corrupt_bit);
		end else begin
			tx_sr <= last_word;
		end
		bit_cnt <= 0;
	end

	// next echo bit after each falling sck
	always @(negedge SPI_SCK) begin
		if (!DAC_CS) begin
			tx_sr <= {tx_sr[30:0], 1'b0};
		end
	end

	assign DAC_OUT = tx_sr[31];

	////////////////////////////////////////
	// capture side
	////////////////////////////////////////

	// mosi latched on rising sck, msb first
	always @(posedge SPI_SCK) begin
		if (!DAC_CS) begin
			rx_sr   <= {rx_sr[30:0], SPI_MOSI};
			bit_cnt <= bit_cnt + 1;
		end
	end

	// only a full 32 bit frame counts
	always @(posedge DAC_CS) begin
		if (bit_cnt == 32) begin
			frame.raw <= rx_sr;
			last_word <= rx_sr;
			frame_cnt <= frame_cnt + 1;
		end
	end

endmodule

// ==== tb/dac_tb.sv ====
`timescale 1ns/1ps

module dac_tb import dac_pkg::*; ();

	localparam int TICK_DIV = 4;
	localparam int ERR_W = 8;
	localparam int N_RANDOM = 200;
	localparam int N_CORRUPT = 40;
	localparam int N_SATURATE = 260;
	localparam int N_BUSY = 4;
	localparam int N_XFER = N_RANDOM + N_CORRUPT + N_SATURATE + N_BUSY;
	// per transfer budget plus room for reset
	localparam int WATCHDOG_CYCLES = N_XFER * (64 * TICK_DIV + 2 * TICK_DIV + 10) + 200;

	logic        CLK50MHZ;
	logic        RST;
	dac_req_t    req;
	logic        dactrig;
	logic        dacdone;
	dac_status_t status;
	logic        DAC_CS;
	logic        DAC_CLR;
	logic        SPI_SCK;
	logic        SPI_MOSI;
	logic        DAC_OUT;
	logic        corrupt;
	logic [4:0]  corrupt_bit;
	dac_frame_u  model_frame;
	int unsigned model_frames;

	int unsigned cyc;
	int unsigned done_cnt;
	int          checks;
	int          errors;
	logic [31:0] rng_state;
	dac_req_t    sent_q[$];
	bit          exp_have_prev;
	logic [7:0]  exp_err;

	dac_subsystem #(
		.TICK_DIV (TICK_DIV),
		.ERR_W    (ERR_W)
	) uut (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.req      (req),
		.dactrig  (dactrig),
		.dacdone  (dacdone),
		.status   (status),
		.DAC_CS   (DAC_CS),
		.DAC_CLR  (DAC_CLR),
		.SPI_SCK  (SPI_SCK),
		.SPI_MOSI (SPI_MOSI),
		.DAC_OUT  (DAC_OUT)
	);

	ltc_dac_model u_model (
		.DAC_CS      (DAC_CS),
		.SPI_SCK     (SPI_SCK),
		.SPI_MOSI    (SPI_MOSI),
		.DAC_OUT     (DAC_OUT),
		.corrupt     (corrupt),
		.corrupt_bit (corrupt_bit),
		.frame       (model_frame),
		.frame_cnt   (model_frames)
	);

	////////////////////////////////////////
	// clock, cycle and done counters
	////////////////////////////////////////

	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	always @(posedge CLK50MHZ) begin
		cyc <= cyc + 1;
	end

	// outputs settle by the falling edge
	always @(negedge CLK50MHZ) begin
		if (dacdone === 1'b1) begin
			done_cnt <= done_cnt + 1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK50MHZ);
		$display("timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////////////////////////
	// stimulus and compare helpers
	////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// upper lcg bits, the low ones repeat quickly
	function automatic dac_req_t make_req();
		logic [31:0] v;
		dac_req_t r;
		v = lcg_next();
		r.cmd = v[31:28];
		r.addr = v[27:24];
		r.data = v[23:12];
		return r;
	endfunction

	task automatic check_frame(input dac_frame_u got, input dac_frame_u exp, input string what);
		checks++;
		if (got.raw !== exp.raw) begin
			errors++;
			$display("FAILED at time %0t: %s got %h expected %h", $time, what, got.raw, exp.raw);
		end
	endtask

	task automatic check_req(input dac_req_t got, input dac_req_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at time %0t: %s got cmd %h addr %h data %h, expected %h %h %h",
				$time, what, got.cmd, got.addr, got.data, exp.cmd, exp.addr, exp.data);
		end
	endtask

	// echo_match has no defined value before the first verdict
	task automatic check_status(input dac_status_t got, input dac_status_t exp,
		input bit match_known, input string what);
		checks++;
		if (got.echo_valid !== exp.echo_valid || got.err_count !== exp.err_count ||
			(match_known && got.echo_match !== exp.echo_match)) begin
			errors++;
			$display("FAILED at time %0t: %s got valid %b match %b errs %0d, expected %b %b %0d",
				$time, what, got.echo_valid, got.echo_match, got.err_count,
				exp.echo_valid, exp.echo_match, exp.err_count);
		end
	endtask

	task automatic check_pin(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int chk0, input int err0);
		$display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
	endtask

	////////////////////////////////////////
	// one transfer, end to end
	////////////////////////////////////////

	task automatic run_transfer(input dac_req_t r, input logic flip, input logic [4:0] flip_bit,
		input bit busy_poke);
		int unsigned fall_cyc;
		int unsigned waited;
		int unsigned frames0;
		int unsigned dones0;
		bit seen;
		dac_frame_u exp_frame;
		dac_status_t exp_status;
		dac_req_t got_req;
		@(posedge CLK50MHZ);
		req <= r;
		dactrig <= 1'b1;
		corrupt <= flip;
		corrupt_bit <= flip_bit;
		frames0 = model_frames;
		dones0 = done_cnt;
		// acceptance waits for the next tick
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < 2 * TICK_DIV + 2) begin
			@(negedge CLK50MHZ);
			waited++;
			seen = (DAC_CS === 1'b0);
		end
		// last verdict pulse is long gone by now
		check_pin(status.echo_valid, 1'b0, "echo_valid between verdicts");
		@(posedge CLK50MHZ);
		dactrig <= 1'b0;
		corrupt <= 1'b0;
		if (!seen) begin
			errors++;
			$display("error: the trigger was never accepted, chip select stayed high");
			return;
		end
		fall_cyc = cyc;
		sent_q.push_back(r);
		// second trigger in mid transfer must be dropped
		if (busy_poke) begin
			repeat (8) @(posedge CLK50MHZ);
			req <= make_req();
			dactrig <= 1'b1;
			repeat (2 * TICK_DIV) @(posedge CLK50MHZ);
			dactrig <= 1'b0;
			req <= r;
		end
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < 70 * TICK_DIV) begin
			@(negedge CLK50MHZ);
			waited++;
			seen = (dacdone === 1'b1);
		end
		if (!seen) begin
			errors++;
			$display("error: no done pulse arrived after chip select fell");
			return;
		end
		// cs rises on the edge that closes the done cycle
		check_count(cyc + 1 - fall_cyc, 64 * TICK_DIV, "transfer length in clocks");
		check_pin(DAC_CS, 1'b0, "DAC_CS in done cycle");
		@(negedge CLK50MHZ);
		check_pin(DAC_CS, 1'b1, "DAC_CS after done");
		check_pin(dacdone, 1'b0, "dacdone after one cycle");
		check_count(done_cnt - dones0, 1, "done pulses in transfer");
		check_count(model_frames - frames0, 1, "frames seen by DAC");
		// verdict on the echo of the transfer before
		if (exp_have_prev && flip && exp_err != 8'hFF) begin
			exp_err = exp_err + 1'b1;
		end
		exp_status.echo_valid = exp_have_prev;
		exp_status.echo_match = !flip;
		exp_status.err_count = exp_err;
		check_status(status, exp_status, exp_have_prev, "echo status");
		exp_have_prev = 1'b1;
		exp_frame.raw = {4'b1000, r.data, r.addr, r.cmd, 8'h01};
		check_frame(model_frame, exp_frame, "captured frame");
		got_req.cmd = model_frame.f.cmd;
		got_req.addr = model_frame.f.addr;
		got_req.data = model_frame.f.data;
		check_req(got_req, sent_q.pop_front(), "decoded request");
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		int chk0;
		int err0;
		dac_status_t idle_status;
		RST = 1'b0;
		req = '0;
		dactrig = 1'b0;
		corrupt = 1'b0;
		corrupt_bit = '0;
		cyc = 0;
		done_cnt = 0;
		checks = 0;
		errors = 0;
		rng_state = 32'd65067;
		exp_have_prev = 1'b0;
		exp_err = '0;
		idle_status = '0;

		// reset held for three rising edges
		chk0 = checks;
		err0 = errors;
		repeat (2) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		check_pin(DAC_CS, 1'b1, "DAC_CS in reset");
		check_pin(SPI_SCK, 1'b0, "SPI_SCK in reset");
		check_pin(dacdone, 1'b0, "dacdone in reset");
		check_pin(DAC_CLR, 1'b0, "DAC_CLR in reset");
		check_status(status, idle_status, 1'b0, "status in reset");
		@(posedge CLK50MHZ);
		RST <= 1'b1;
		@(negedge CLK50MHZ);
		check_pin(DAC_CS, 1'b1, "DAC_CS after reset");
		check_pin(SPI_SCK, 1'b0, "SPI_SCK after reset");
		check_pin(dacdone, 1'b0, "dacdone after reset");
		check_pin(DAC_CLR, 1'b1, "DAC_CLR after reset");
		check_status(status, idle_status, 1'b0, "status after reset");
		report_test("reset state", chk0, err0);

		// clean echoes, frame layout and timing
		chk0 = checks;
		err0 = errors;
		for (int i = 0; i < N_RANDOM; i++) begin
			run_transfer(make_req(), 1'b0, 5'd0, 1'b0);
		end
		report_test("frames, timing and clean echo", chk0, err0);

		// flipped bit lands in cmd, addr or data
		chk0 = checks;
		err0 = errors;
		for (int i = 0; i < N_CORRUPT; i++) begin
			run_transfer(make_req(), ((lcg_next() >> 8) % 3) == 0,
				5'(8 + (lcg_next() >> 16) % 20), 1'b0);
		end
		report_test("echo mismatch count", chk0, err0);

		// every echo flipped, counter runs into its ceiling and stays
		chk0 = checks;
		err0 = errors;
		for (int i = 0; i < N_SATURATE; i++) begin
			run_transfer(make_req(), 1'b1, 5'(8 + (lcg_next() >> 16) % 20), 1'b0);
		end
		report_test("error count saturation", chk0, err0);

		chk0 = checks;
		err0 = errors;
		for (int i = 0; i < N_BUSY; i++) begin
			run_transfer(make_req(), 1'b0, 5'd0, 1'b1);
		end
		report_test("trigger while busy", chk0, err0);

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
hdl/dac_pkg.sv
hdl/sck_tick_gen.sv
hdl/spi_shifter.sv
hdl/dacspi.sv
hdl/echo_checker.sv
hdl/dac_subsystem.sv
tb/ltc_dac_model.sv
tb/dac_tb.sv

// ==== Bender.yml ====
package:
  name: dac_subsystem

sources:
  - files:
      - hdl/dac_pkg.sv
      - hdl/sck_tick_gen.sv
      - hdl/spi_shifter.sv
      - hdl/dacspi.sv
      - hdl/echo_checker.sv
      - hdl/dac_subsystem.sv
  - target: simulation
    files:
      - tb/ltc_dac_model.sv
      - tb/dac_tb.sv
